//--- src.f
+incdir+source
source/cache_pkg.sv
source/cache_array.sv
source/cache_way.sv
source/cache_datapath.sv
source/cache_control.sv
source/cache_top.sv
testbench/cache_clock.sv
testbench/cache_assertions.sv
testbench/cache_tb.sv

//--- testbench/cache_tb.sv
//********************************************************************
// testbench for the two-way cache. random line traffic over 4 tags,
// a memory with random delay and a model of sets, ways and memory
//********************************************************************

`timescale 1ns/1ps
`default_nettype none

module cache_tb;

    import cache_pkg::*;

    localparam int          NUM_REQUESTS = 400;
    localparam int          CLK_PERIOD   = 4;
    localparam int          TIMEOUT_NS   = (NUM_REQUESTS * 50 + 10) * CLK_PERIOD;
    localparam logic [31:0] SEED         = 32'hbb5e_e022;

    logic       clk;
    logic       rst_n;
    logic       cpu_read;
    logic       cpu_write;
    addr_t      cpu_address;
    line_t      cpu_wdata;
    byte_mask_t cpu_byte_en;
    logic       cpu_resp;
    line_t      cpu_rdata;
    logic       pmem_resp;
    line_t      pmem_rdata;
    logic       pmem_read;
    logic       pmem_write;
    addr_t      pmem_address;
    line_t      pmem_wdata;

    logic [31:0] cpu_rng;
    logic [31:0] mem_rng;

    // model state of the cpu view of memory, real memory and per-set tags
    line_t model_mem [addr_t];
    line_t phys_mem [addr_t];
    logic  m_valid [8][2];
    logic  m_dirty [8][2];
    tag_t  m_tag [8][2];
    logic  m_lru [8];
    tag_t  tag_pool [4] = '{24'h000000, 24'h000001, 24'h5c3a91, 24'hfff0f0};

    // memory transfers seen since the last cpu response
    logic  txn_write [$];
    addr_t txn_addr [$];
    line_t txn_data [$];

    cache_clock clock_gen (.clk_o(clk));

    cache_top uut (
        .clk            (clk),
        .rst_n_i        (rst_n),
        .cpu_read_i     (cpu_read),
        .cpu_write_i    (cpu_write),
        .cpu_address_i  (cpu_address),
        .cpu_wdata_i    (cpu_wdata),
        .cpu_byte_en_i  (cpu_byte_en),
        .cpu_resp_o     (cpu_resp),
        .cpu_rdata_o    (cpu_rdata),
        .pmem_resp_i    (pmem_resp),
        .pmem_rdata_i   (pmem_rdata),
        .pmem_read_o    (pmem_read),
        .pmem_write_o   (pmem_write),
        .pmem_address_o (pmem_address),
        .pmem_wdata_o   (pmem_wdata)
    );

    bind cache_top cache_assertions port_checks (
        .clk_i          (clk),
        .rst_n_i        (rst_n_i),
        .cpu_read_i     (cpu_read_i),
        .cpu_write_i    (cpu_write_i),
        .pmem_read_i    (pmem_read_o),
        .pmem_write_i   (pmem_write_o),
        .pmem_resp_i    (pmem_resp_i),
        .pmem_address_i (pmem_address_o),
        .pmem_wdata_i   (pmem_wdata_o)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // untouched memory where every word mixes in the whole address
    function automatic line_t fill_pattern(input addr_t addr);
        line_t line;
        for (int i = 0; i < 8; i++) begin
            line[32*i +: 32] = xorshift32(addr + 32'(i) + 32'h1000_0001);
        end
        return line;
    endfunction

    function automatic line_t model_line(input addr_t addr);
        return model_mem.exists(addr) ? model_mem[addr] : fill_pattern(addr);
    endfunction

    function automatic line_t phys_line(input addr_t addr);
        return phys_mem.exists(addr) ? phys_mem[addr] : fill_pattern(addr);
    endfunction

    function automatic line_t merge_bytes(input line_t old_line, input line_t new_line,
                                          input byte_mask_t mask);
        line_t result;
        result = old_line;
        for (int b = 0; b < 32; b++) begin
            if (mask[b]) begin
                result[8*b +: 8] = new_line[8*b +: 8];
            end
        end
        return result;
    endfunction

    task automatic check_value(input line_t actual, input line_t expected, input string what);
        if (actual !== expected) begin
            $display("error at %0t: %s, got %h, expected %h", $time, what, actual, expected);
            $display("Finished with errors");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    // answers each strobe after 0 to 3 extra cycles and logs the transfer
    task automatic serve_memory();
        addr_t addr;
        int    delay;
        forever begin
            @(negedge clk);
            if (rst_n && (pmem_read || pmem_write)) begin
                addr    = pmem_address;
                mem_rng = xorshift32(mem_rng);
                delay   = int'(mem_rng % 4);
                repeat (delay) @(negedge clk);
                @(posedge clk);
                #1;
                pmem_resp  = 1'b1;
                pmem_rdata = phys_line(addr);
                @(negedge clk);
                txn_write.push_back(pmem_write);
                txn_addr.push_back(pmem_address);
                txn_data.push_back(pmem_wdata);
                if (pmem_write) begin
                    phys_mem[pmem_address] = pmem_wdata;
                end
                @(posedge clk);
                #1;
                pmem_resp  = 1'b0;
                pmem_rdata = '0;
            end
        end
    endtask

    task automatic run_request();
        addr_t      addr;
        addr_t      line_addr;
        addr_t      victim_addr;
        index_t     set_idx;
        tag_t       tag;
        line_t      wdata;
        byte_mask_t mask;
        logic       is_write;
        logic       hit;
        logic       way;
        logic       writeback;
        logic       saw_strobe;
        int         cycles;

        cpu_rng = xorshift32(cpu_rng);
        tag      = tag_pool[cpu_rng[1:0]];
        set_idx  = cpu_rng[4:2];
        is_write = cpu_rng[10];
        addr      = {tag, set_idx, cpu_rng[9:5]};
        line_addr = {tag, set_idx, 5'b0};
        mask      = cpu_rng[11] ? '1 : xorshift32(cpu_rng ^ 32'h00ff_00ff);
        for (int i = 0; i < 8; i++) begin
            cpu_rng = xorshift32(cpu_rng);
            wdata[32*i +: 32] = cpu_rng;
        end

        // prediction from the model before the request goes out
        hit = 1'b0;
        way = m_lru[set_idx];
        for (int w = 0; w < 2; w++) begin
            if (m_valid[set_idx][w] && m_tag[set_idx][w] == tag) begin
                hit = 1'b1;
                way = w[0];
            end
        end
        writeback   = !hit && m_valid[set_idx][way] && m_dirty[set_idx][way];
        victim_addr = {m_tag[set_idx][way], set_idx, 5'b0};

        @(posedge clk);
        #1;
        cpu_read    = !is_write;
        cpu_write   = is_write;
        cpu_address = addr;
        cpu_wdata   = wdata;
        cpu_byte_en = mask;

        cycles     = 0;
        saw_strobe = 1'b0;
        do begin
            @(negedge clk);
            cycles++;
            saw_strobe |= pmem_read | pmem_write;
        end while (!cpu_resp);

        if (hit) begin
            check_value(saw_strobe, 0, "memory strobe on a predicted hit");
            check_value(cycles, 1, "hit response latency in cycles");
        end
        check_value(txn_write.size(), hit ? 0 : (writeback ? 2 : 1), "memory transfers");
        if (writeback) begin
            check_value(txn_write[0], 1, "first transfer of a dirty miss is a write");
            check_value(txn_addr[0], victim_addr, "write-back address");
            check_value(txn_data[0], model_line(victim_addr), "write-back data");
        end
        if (!hit) begin
            check_value(txn_write[$], 0, "fill transfer is a read");
            check_value(txn_addr[$], line_addr, "fill address");
        end
        if (!is_write) begin
            check_value(cpu_rdata, model_line(line_addr), "read data");
        end

        // model update where the fill lands in the lru way
        if (!hit) begin
            m_valid[set_idx][way] = 1'b1;
            m_dirty[set_idx][way] = 1'b0;
            m_tag[set_idx][way]   = tag;
        end
        m_lru[set_idx] = ~way;
        if (is_write) begin
            model_mem[line_addr]  = merge_bytes(model_line(line_addr), wdata, mask);
            m_dirty[set_idx][way] = 1'b1;
        end
        txn_write.delete();
        txn_addr.delete();
        txn_data.delete();
    endtask

    // one cycle with no request where nothing may respond
    task automatic idle_cycle();
        @(posedge clk);
        #1;
        cpu_read  = 1'b0;
        cpu_write = 1'b0;
        @(negedge clk);
        check_value(cpu_resp, 0, "response without a request");
        check_value(pmem_read | pmem_write, 0, "memory strobe without a request");
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired: requests did not finish within %0d ns", TIMEOUT_NS);
        $display("Finished with errors");
        $fatal(1, "run timed out");
    end

    // a failing port assertion ends the run
    initial begin
        wait (uut.port_checks.error_count != 0);
        $display("a port assertion on the cache failed at %0t", $time);
        $display("Finished with errors");
        $fatal(1, "port assertion failed");
    end

    initial begin
        cpu_rng     = SEED;
        mem_rng     = {SEED[15:0], SEED[31:16]};
        rst_n       = 1'b0;
        cpu_read    = 1'b0;
        cpu_write   = 1'b0;
        cpu_address = '0;
        cpu_wdata   = '0;
        cpu_byte_en = '0;
        pmem_resp   = 1'b0;
        pmem_rdata  = '0;
        m_valid     = '{default: '0};
        m_dirty     = '{default: '0};
        m_tag       = '{default: '0};
        m_lru       = '{default: '0};

        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        check_value(cpu_resp, 0, "cpu response after reset");
        check_value(pmem_read, 0, "memory read after reset");
        check_value(pmem_write, 0, "memory write after reset");

        fork
            serve_memory();
        join_none

        for (int n = 0; n < NUM_REQUESTS; n++) begin
            run_request();
            cpu_rng = xorshift32(cpu_rng);
            if (cpu_rng[0]) begin
                idle_cycle();
            end
        end

        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/cache_assertions.sv
//********************************************************************
// port checks for the cache top level, attached with bind from the
// testbench. cpu strobes exclusive, memory strobes aligned and held
//********************************************************************

`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

module cache_assertions (
    input wire                   clk_i,
    input wire                   rst_n_i,
    input wire                   cpu_read_i,
    input wire                   cpu_write_i,
    input wire                   pmem_read_i,
    input wire                   pmem_write_i,
    input wire                   pmem_resp_i,
    input wire cache_pkg::addr_t pmem_address_i,
    input wire cache_pkg::line_t pmem_wdata_i
);

    // number of failed assertions
    int error_count = 0;

    cpu_strobes_exclusive: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        !(cpu_read_i && cpu_write_i)
    ) else begin
        $error("cpu read and write asserted together");
        error_count++;
    end

    // memory only ever sees whole lines
    pmem_address_aligned: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (pmem_read_i || pmem_write_i) |-> pmem_address_i[`CACHE_S_OFFSET-1:0] == '0
    ) else begin
        $error("memory address not line aligned");
        error_count++;
    end

    pmem_read_held: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        pmem_read_i && !pmem_resp_i |=> pmem_read_i && $stable(pmem_address_i)
    ) else begin
        $error("memory read dropped or changed before its response");
        error_count++;
    end

    pmem_write_held: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        pmem_write_i && !pmem_resp_i
            |=> pmem_write_i && $stable(pmem_address_i) && $stable(pmem_wdata_i)
    ) else begin
        $error("memory write dropped or changed before its response");
        error_count++;
    end

endmodule

`default_nettype wire

//--- testbench/cache_clock.sv
//********************************************************************
// free-running testbench clock with a 4 ns period, starting low
//********************************************************************

`timescale 1ns/1ps
`default_nettype none

module cache_clock #(
    parameter int HALF_PERIOD_NS = 2
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(HALF_PERIOD_NS) clk_o = ~clk_o;
        end
    end

endmodule

`default_nettype wire

//--- source/cache_top.sv
//********************************************************************
// cache top level. cpu side moves whole lines with a byte mask,
// memory side moves aligned lines; both hold requests until resp
//********************************************************************

`timescale 1ns/1ps
`default_nettype none

module cache_top (
    input  wire                        clk,
    input  wire                        rst_n_i,
    input  wire                        cpu_read_i,
    input  wire                        cpu_write_i,
    input  wire cache_pkg::addr_t      cpu_address_i,
    input  wire cache_pkg::line_t      cpu_wdata_i,
    input  wire cache_pkg::byte_mask_t cpu_byte_en_i,
    output logic                       cpu_resp_o,
    output cache_pkg::line_t           cpu_rdata_o,
    input  wire                        pmem_resp_i,
    input  wire cache_pkg::line_t      pmem_rdata_i,
    output logic                       pmem_read_o,
    output logic                       pmem_write_o,
    output cache_pkg::addr_t           pmem_address_o,
    output cache_pkg::line_t           pmem_wdata_o
);

    // controller to datapath
    logic access_sel;
    logic address_sel;
    logic load;
    logic load_lru;
    logic hit;
    logic dirty;

    cache_control control (
        .clk,
        .rst_n_i,
        .cpu_read_i,
        .cpu_write_i,
        .hit_i         (hit),
        .dirty_i       (dirty),
        .pmem_resp_i,
        .cpu_resp_o,
        .pmem_read_o,
        .pmem_write_o,
        .access_sel_o  (access_sel),
        .address_sel_o (address_sel),
        .load_o        (load),
        .load_lru_o    (load_lru)
    );

    cache_datapath datapath (
        .clk,
        .rst_n_i,
        .access_sel_i  (access_sel),
        .address_sel_i (address_sel),
        .load_i        (load),
        .load_lru_i    (load_lru),
        .cpu_address_i,
        .cpu_wdata_i,
        .cpu_byte_en_i,
        .pmem_rdata_i,
        .hit_o         (hit),
        .dirty_o       (dirty),
        .cpu_rdata_o,
        .pmem_address_o,
        .pmem_wdata_o
    );

endmodule

`default_nettype wire

//--- source/cache_control.sv
//********************************************************************
// cache controller FSM that compares, writes back a dirty victim and
// fills the line. outputs are decoded from the state and held
//********************************************************************

`timescale 1ns/1ps
`default_nettype none

module cache_control (
    input  wire  clk,
    input  wire  rst_n_i,
    input  wire  cpu_read_i,
    input  wire  cpu_write_i,
    input  wire  hit_i,
    input  wire  dirty_i,
    input  wire  pmem_resp_i,
    output logic cpu_resp_o,
    output logic pmem_read_o,
    output logic pmem_write_o,
    output logic access_sel_o,
    output logic address_sel_o,
    output logic load_o,
    output logic load_lru_o
);

    import cache_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_next;
    logic        request;

    assign request = cpu_read_i | cpu_write_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state <= COMPARE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next    = state;
        cpu_resp_o    = 1'b0;
        pmem_read_o   = 1'b0;
        pmem_write_o  = 1'b0;
        access_sel_o  = 1'b0;
        address_sel_o = 1'b0;
        load_o        = 1'b0;
        load_lru_o    = 1'b0;

        unique case (state)
            COMPARE: begin
                if (request) begin
                    if (hit_i) begin
                        // answer in the same cycle while the update lands at the edge
                        cpu_resp_o = 1'b1;
                        load_lru_o = 1'b1;
                        load_o     = cpu_write_i;
                    end else if (dirty_i) begin
                        state_next = WRITEBACK;
                    end else begin
                        state_next = FILL;
                    end
                end
            end

            WRITEBACK: begin
                pmem_write_o  = 1'b1;
                address_sel_o = 1'b1;
                if (pmem_resp_i) begin
                    state_next = FILL;
                end
            end

            FILL: begin
                pmem_read_o  = 1'b1;
                access_sel_o = 1'b1;
                // line arrives with the response and goes into the victim
                if (pmem_resp_i) begin
                    load_o     = 1'b1;
                    state_next = COMPARE;
                end
            end

            default: begin
                state_next = COMPARE;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- source/cache_datapath.sv
//********************************************************************
// two ways plus the per-set lru bit. splits the cpu address, steers
// the load to the hit or victim way and muxes data to both ports
//********************************************************************

`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

module cache_datapath (
    input  wire                        clk,
    input  wire                        rst_n_i,
    input  wire                        access_sel_i,
    input  wire                        address_sel_i,
    input  wire                        load_i,
    input  wire                        load_lru_i,
    input  wire cache_pkg::addr_t      cpu_address_i,
    input  wire cache_pkg::line_t      cpu_wdata_i,
    input  wire cache_pkg::byte_mask_t cpu_byte_en_i,
    input  wire cache_pkg::line_t      pmem_rdata_i,
    output logic                       hit_o,
    output logic                       dirty_o,
    output cache_pkg::line_t           cpu_rdata_o,
    output cache_pkg::addr_t           pmem_address_o,
    output cache_pkg::line_t           pmem_wdata_o
);

    import cache_pkg::*;

    index_t     index;
    tag_t       tag;
    tag_t       tag_0;
    tag_t       tag_1;
    logic       hit_0;
    logic       hit_1;
    logic       dirty_0;
    logic       dirty_1;
    logic       load_0;
    logic       load_1;
    logic       lru;
    logic       lru_in;
    line_t      data_in;
    line_t      data_0;
    line_t      data_1;
    byte_mask_t write_mask;

    assign index = cpu_address_i[`CACHE_S_OFFSET +: `CACHE_S_INDEX];
    assign tag   = cpu_address_i[`CACHE_ADDR_W-1 -: `CACHE_S_TAG];

    // fills write the whole line, stores only the enabled bytes
    assign data_in    = access_sel_i ? pmem_rdata_i : cpu_wdata_i;
    assign write_mask = access_sel_i ? '1 : cpu_byte_en_i;

    // on a miss the load goes to the lru way, which is the victim
    always_comb begin
        load_0 = 1'b0;
        load_1 = 1'b0;
        if (hit_1) begin
            load_1 = load_i;
        end else if (hit_0) begin
            load_0 = load_i;
        end else if (lru) begin
            load_1 = load_i;
        end else begin
            load_0 = load_i;
        end
    end

    // lru points at the way that was not just used
    assign lru_in = hit_0 ? 1'b1 : (hit_1 ? 1'b0 : ~lru);

    assign hit_o       = hit_0 | hit_1;
    assign dirty_o     = lru ? dirty_1 : dirty_0;
    assign cpu_rdata_o = hit_1 ? data_1 : data_0;

    // write-back uses the victim's own tag, not the cpu's
    assign pmem_wdata_o   = lru ? data_1 : data_0;
    assign pmem_address_o = address_sel_i
                          ? {(lru ? tag_1 : tag_0), index, {`CACHE_S_OFFSET{1'b0}}}
                          : {tag, index, {`CACHE_S_OFFSET{1'b0}}};

    cache_way way_0 (
        .clk,
        .rst_n_i,
        .load_i       (load_0),
        .access_sel_i,
        .index_i      (index),
        .tag_i        (tag),
        .mask_i       (write_mask),
        .data_i       (data_in),
        .hit_o        (hit_0),
        .dirty_o      (dirty_0),
        .tag_o        (tag_0),
        .data_o       (data_0)
    );

    cache_way way_1 (
        .clk,
        .rst_n_i,
        .load_i       (load_1),
        .access_sel_i,
        .index_i      (index),
        .tag_i        (tag),
        .mask_i       (write_mask),
        .data_i       (data_in),
        .hit_o        (hit_1),
        .dirty_o      (dirty_1),
        .tag_o        (tag_1),
        .data_o       (data_1)
    );

    cache_array #(.payload_t(logic)) lru_array (
        .clk,
        .rst_n_i,
        .load_i  (load_lru_i),
        .index_i (index),
        .data_i  (lru_in),
        .data_o  (lru)
    );

endmodule

`default_nettype wire

//--- source/cache_way.sv
//********************************************************************
// one way of the cache with valid, dirty, tag and data arrays, the tag
// compare and the byte-masked merge used by cpu stores and line fills
//********************************************************************

`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

module cache_way (
    input  wire                        clk,
    input  wire                        rst_n_i,
    input  wire                        load_i,
    input  wire                        access_sel_i,
    input  wire cache_pkg::index_t     index_i,
    input  wire cache_pkg::tag_t       tag_i,
    input  wire cache_pkg::byte_mask_t mask_i,
    input  wire cache_pkg::line_t      data_i,
    output logic                       hit_o,
    output logic                       dirty_o,
    output cache_pkg::tag_t            tag_o,
    output cache_pkg::line_t           data_o
);

    import cache_pkg::*;

    logic  valid_q;
    logic  dirty_q;
    logic  fill_load;
    line_t line_q;
    line_t line_merged;

    // valid and tag only change when a line comes in from memory
    assign fill_load = load_i & access_sel_i;

    cache_array #(.payload_t(logic)) valid_array (
        .clk,
        .rst_n_i,
        .load_i  (fill_load),
        .index_i,
        .data_i  (1'b1),
        .data_o  (valid_q)
    );

    // cpu store marks the line dirty, a fill cleans it
    cache_array #(.payload_t(logic)) dirty_array (
        .clk,
        .rst_n_i,
        .load_i,
        .index_i,
        .data_i  (~access_sel_i),
        .data_o  (dirty_q)
    );

    cache_array #(.payload_t(tag_t)) tag_array (
        .clk,
        .rst_n_i,
        .load_i  (fill_load),
        .index_i,
        .data_i  (tag_i),
        .data_o  (tag_o)
    );

    cache_array #(.payload_t(line_t)) data_array (
        .clk,
        .rst_n_i,
        .load_i,
        .index_i,
        .data_i  (line_merged),
        .data_o  (line_q)
    );

    always_comb begin
        for (int i = 0; i < `CACHE_LINE_BYTES; i++) begin
            line_merged[8*i +: 8] = mask_i[i] ? data_i[8*i +: 8] : line_q[8*i +: 8];
        end
    end

    assign hit_o   = valid_q && (tag_o == tag_i);
    assign dirty_o = valid_q & dirty_q;
    assign data_o  = line_q;

endmodule

`default_nettype wire

//--- source/cache_array.sv
//********************************************************************
// one entry per set, read combinationally, written on the rising edge.
// payload_t picks what an entry holds (valid, dirty, tag, line or lru)
//********************************************************************

`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

module cache_array #(
    parameter type payload_t = logic
) (
    input  wire                    clk,
    input  wire                    rst_n_i,
    input  wire                    load_i,
    input  wire cache_pkg::index_t index_i,
    input  wire payload_t          data_i,
    output payload_t               data_o
);

    localparam int NUM_SETS = 2 ** `CACHE_S_INDEX;

    payload_t entries [NUM_SETS];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NUM_SETS; i++) begin
                entries[i] <= '0;
            end
        end else if (load_i) begin
            entries[index_i] <= data_i;
        end
    end

    // read port is asynchronous so lookup and update share a cycle
    assign data_o = entries[index_i];

endmodule

`default_nettype wire

//--- source/cache_pkg.sv
//********************************************************************
// shared types of the cache, sized from the constants header.
// modules name them with cache_pkg:: in ports, import in bodies
//********************************************************************

`default_nettype none

`include "cache_consts.svh"

package cache_pkg;

    typedef logic [`CACHE_ADDR_W-1:0]       addr_t;
    typedef logic [`CACHE_S_INDEX-1:0]      index_t;
    typedef logic [`CACHE_S_TAG-1:0]        tag_t;
    typedef logic [8*`CACHE_LINE_BYTES-1:0] line_t;
    typedef logic [`CACHE_LINE_BYTES-1:0]   byte_mask_t;

    // controller states
    typedef enum logic [1:0] {
        COMPARE   = 2'd0,
        WRITEBACK = 2'd1,
        FILL      = 2'd2
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- source/cache_consts.svh
//********************************************************************
// offset, index, tag and address widths and the line size of the
// two-way cache. include wherever the widths or set count are needed
//********************************************************************

`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// byte offset inside a 32-byte line
`define CACHE_S_OFFSET 5

// eight sets
`define CACHE_S_INDEX 3

`define CACHE_ADDR_W 32

// whatever is left of the address above index and offset
`define CACHE_S_TAG (`CACHE_ADDR_W - `CACHE_S_INDEX - `CACHE_S_OFFSET)

`define CACHE_LINE_BYTES 32

`endif
